// File: compile.f
+incdir+design
design/types.sv
design/timeout.sv
design/brightness_timeout.sv
design/matrix_scan.sv
design/pixel_fetch.sv
design/hub75_top.sv
verification/hub75_checker.sv
verification/hub75_tb.sv

// File: design/brightness_timeout.sv
// output enable pulse generator for binary-coded modulation
// pulse length is the base time scaled by the weight of the active plane

`timescale 1ns/10ps

`include "hub75_consts.svh"

module brightness_timeout (
    input  logic                      clk_in,
    input  logic                      reset,
    input  logic                      row_latch,
    input  types::brightness_level_t  brightness_mask_active,
    output logic                      output_enable,
    output logic                      exceeded_overlap_time
);

    import types::*;

    // longest pulse is the MSB plane
    localparam int unsigned OE_MAX = `HUB75_OE_BASE_CYCLES << (`HUB75_BRIGHTNESS_BITS - 1);
    localparam int unsigned OE_WIDTH = $clog2(OE_MAX + 1);

    // cycles of enable still to go
    logic [OE_WIDTH-1:0] oe_remaining;
    // length of the pulse for the plane just latched
    logic [OE_WIDTH-1:0] pulse_cycles;

    // one-hot mask to base cycles shifted left by the bit index
    function automatic logic [OE_WIDTH-1:0] weighted_cycles(input brightness_level_t mask);
        logic [OE_WIDTH-1:0] cycles;
        cycles = '0;
        for (int i = 0; i < `HUB75_BRIGHTNESS_BITS; i++) begin
            if (mask[i]) begin
                cycles = OE_WIDTH'(`HUB75_OE_BASE_CYCLES << i);
            end
        end
        return cycles;
    endfunction

    assign pulse_cycles = weighted_cycles(brightness_mask_active);

    // latch loads the full pulse, then count down to zero
    always_ff @(posedge clk_in) begin
        if (reset) begin
            oe_remaining <= '0;
        end else if (row_latch) begin
            oe_remaining <= pulse_cycles;
        end else if (oe_remaining != '0) begin
            oe_remaining <= oe_remaining - 1'b1;
        end
    end

    // LEDs lit while time remains
    assign output_enable = (oe_remaining != '0);

    // near the end of the pulse the next plane may begin shifting
    assign exceeded_overlap_time = output_enable &&
                                   (32'(oe_remaining) <= `HUB75_OVERLAP_CYCLES);

endmodule

// File: design/hub75_consts.svh
// HUB75 scan controller constants
// panel geometry and scan timing shared by the design and the testbench

`ifndef HUB75_CONSTS_SVH
`define HUB75_CONSTS_SVH

// columns per row, one pixel clock each
`define HUB75_PIXEL_WIDTH 32

// rows per subpanel
// the upper and lower halves share the row lines
`define HUB75_SUBPANEL_ROWS 16

// bits per colour channel
// also the number of binary-weighted planes per row
`define HUB75_BRIGHTNESS_BITS 4

// clk_in cycles of output enable for the LSB plane
// each higher plane doubles this
`define HUB75_OE_BASE_CYCLES 8

// once the remaining enable time drops to this many cycles
// the next plane may start shifting
`define HUB75_OVERLAP_CYCLES 40

`endif

// File: design/hub75_top.sv
// HUB75 controller top level
// scan sequencer plus framebuffer, panel signals and write port at the pins

`timescale 1ns/10ps

module hub75_top (
    input  logic                      clk_in,
    input  logic                      reset,
    // framebuffer write port
    input  logic                      wr_en,
    input  types::fb_addr_t           wr_addr,
    input  types::channel_t [2:0]     wr_data,
    // colour lines, upper then lower subpanel
    output logic                      r0,
    output logic                      g0,
    output logic                      b0,
    output logic                      r1,
    output logic                      g1,
    output logic                      b1,
    // panel control
    output logic                      clk_pixel,
    output logic                      row_latch,
    output logic                      output_enable,
    output types::row_subpanel_addr_t row_address_active,
    // shifting column, for observation
    output types::col_addr_t          column_address
);

    import types::*;

    // sequencer to framebuffer
    row_subpanel_addr_t row_address;
    brightness_level_t  brightness_mask;
    logic               clk_pixel_load;

    matrix_scan scan (
        .reset             (reset),
        .clk_in            (clk_in),
        .column_address    (column_address),
        .row_address       (row_address),
        .row_address_active(row_address_active),
        .clk_pixel_load    (clk_pixel_load),
        .clk_pixel         (clk_pixel),
        .row_latch         (row_latch),
        .output_enable     (output_enable),
        .brightness_mask   (brightness_mask)
    );

    pixel_fetch fetch (
        .clk_in         (clk_in),
        .reset          (reset),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .clk_pixel_load (clk_pixel_load),
        .column_address (column_address),
        .row_address    (row_address),
        .brightness_mask(brightness_mask),
        .r0             (r0),
        .g0             (g0),
        .b0             (b0),
        .r1             (r1),
        .g1             (g1),
        .b1             (b1)
    );

endmodule

// File: design/matrix_scan.sv
// HUB75 row, column and brightness plane sequencer
// shifts one plane per row, latches it, and times output enable by plane weight

`timescale 1ns/10ps

`include "hub75_consts.svh"

module matrix_scan (
    input  logic                      reset,
    input  logic                      clk_in,
    // column being shifted out now
    output types::col_addr_t          column_address,
    // row being shifted out now
    output types::row_subpanel_addr_t row_address,
    // row whose LEDs are lit
    output types::row_subpanel_addr_t row_address_active,
    output logic                      clk_pixel_load,
    output logic                      clk_pixel,
    output logic                      row_latch,
    output logic                      output_enable,
    // plane being shifted out now
    output types::brightness_level_t  brightness_mask
);

    import types::*;

    localparam int unsigned LOAD_WIDTH = $clog2(`HUB75_PIXEL_WIDTH + 1);
    localparam int unsigned COL_WIDTH = $bits(col_addr_t);
    localparam brightness_level_t MASK_MSB =
        brightness_level_t'(1) << (`HUB75_BRIGHTNESS_BITS - 1);

    // plane start detection
    logic [1:0] state;
    logic       state_advance;
    logic       plane_start;
    logic       scan_busy;

    // load window straight from the counter, posedge domain
    logic clk_pixel_load_en;
    // same window moved to the falling edge, gates the load clock cleanly
    logic load_gate;
    // half a cycle later again, gates the inverted clock
    logic clk_pixel_en;

    latch_phase_t latch_phase;

    // plane that is lit, loaded as the latch opens
    brightness_level_t brightness_mask_active;
    logic              exceeded_overlap_time;

    // PIXEL_WIDTH load clocks per plane
    timeout #(
        .COUNTER_WIDTH(LOAD_WIDTH)
    ) load_window (
        .reset  (reset),
        .clk_in (clk_in),
        .start  (plane_start),
        .value  (LOAD_WIDTH'(`HUB75_PIXEL_WIDTH)),
        .counter(),
        .running(clk_pixel_load_en)
    );

    // column address runs WIDTH-1 down to 0 and stops
    timeout #(
        .COUNTER_WIDTH(COL_WIDTH)
    ) column_counter (
        .reset  (reset),
        .clk_in (clk_in),
        .start  (plane_start),
        .value  (COL_WIDTH'(`HUB75_PIXEL_WIDTH - 1)),
        .counter(column_address),
        .running()
    );

    brightness_timeout oe_timer (
        .clk_in                (clk_in),
        .reset                 (reset),
        .row_latch             (row_latch),
        .brightness_mask_active(brightness_mask_active),
        .output_enable         (output_enable),
        .exceeded_overlap_time (exceeded_overlap_time)
    );

    // a plane is in flight from its start pulse until the latch closes
    assign scan_busy = clk_pixel_load_en || load_gate || (latch_phase != IDLE);

    // start the next plane once the lit one is dark or nearly done
    assign state_advance = (!output_enable || exceeded_overlap_time) && !scan_busy;

    // rising edge of the advance condition, one pulse per plane
    assign plane_start = (state == 2'b01);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= 2'b00;
            clk_pixel_en <= 1'b0;
        end else begin
            state <= {state[0], state_advance};
            clk_pixel_en <= load_gate;
        end
    end

    // gated clocks, enables only change while their clock is low
    assign clk_pixel_load = clk_in && load_gate;
    assign clk_pixel = !clk_in && clk_pixel_en;

    assign row_latch = (latch_phase == LATCH);

    // load gate, latch phase and plane bookkeeping on the falling edge
    always_ff @(negedge clk_in) begin
        if (reset) begin
            load_gate <= 1'b0;
            latch_phase <= IDLE;
            brightness_mask <= MASK_MSB;
            brightness_mask_active <= '0;
            row_address <= '0;
            row_address_active <= '0;
        end else begin
            load_gate <= clk_pixel_load_en;
            case (latch_phase)
                IDLE: begin
                    if (load_gate) begin
                        latch_phase <= SHIFT;
                    end
                end
                SHIFT: begin
                    // all columns out, and the previous plane has gone dark
                    if (!load_gate && !output_enable) begin
                        latch_phase <= LATCH;
                        brightness_mask_active <= brightness_mask;
                        row_address_active <= row_address;
                        if (brightness_mask == brightness_level_t'(1)) begin
                            // last plane of the row, back to MSB on the next row
                            brightness_mask <= MASK_MSB;
                            if (row_address == row_subpanel_addr_t'(`HUB75_SUBPANEL_ROWS - 1)) begin
                                row_address <= '0;
                            end else begin
                                row_address <= row_address + 1'b1;
                            end
                        end else begin
                            brightness_mask <= brightness_mask >> 1;
                        end
                    end
                end
                LATCH: begin
                    latch_phase <= IDLE;
                end
                default: begin
                    latch_phase <= IDLE;
                end
            endcase
        end
    end

endmodule

// File: design/pixel_fetch.sv
// dual-subpanel framebuffer with a write port
// picks one brightness plane bit per colour line for the shifting column

`timescale 1ns/10ps

module pixel_fetch (
    input  logic                      clk_in,
    input  logic                      reset,
    // write port, sampled on the clk_in rising edge
    input  logic                      wr_en,
    input  types::fb_addr_t           wr_addr,
    // [2] red, [1] green, [0] blue
    input  types::channel_t [2:0]     wr_data,
    // read side, driven by the scan sequencer
    input  logic                      clk_pixel_load,
    input  types::col_addr_t          column_address,
    input  types::row_subpanel_addr_t row_address,
    input  types::brightness_level_t  brightness_mask,
    // upper subpanel
    output logic                      r0,
    output logic                      g0,
    output logic                      b0,
    // lower subpanel
    output logic                      r1,
    output logic                      g1,
    output logic                      b1
);

    import types::*;

    localparam int unsigned COL_BITS = $bits(col_addr_t);
    localparam int unsigned ROW_BITS = $bits(row_subpanel_addr_t);
    localparam int unsigned CELL_BITS = ROW_BITS + COL_BITS;
    localparam int unsigned DEPTH = 2 ** CELL_BITS;

    // {row, column} within one subpanel
    typedef logic [CELL_BITS-1:0] cell_addr_t;

    // one RGB pixel per word
    channel_t [2:0] upper_mem [DEPTH];
    channel_t [2:0] lower_mem [DEPTH];

    logic           wr_lower;
    cell_addr_t     wr_cell;
    cell_addr_t     rd_cell;
    channel_t [2:0] upper_pixel;
    channel_t [2:0] lower_pixel;
    logic [5:0]     plane_bits;

    // bit of a channel that belongs to the selected plane
    function automatic logic plane_bit(input channel_t value, input brightness_level_t mask);
        return |(value & mask);
    endfunction

    // top address bit chooses the subpanel
    assign wr_lower = wr_addr[CELL_BITS];
    assign wr_cell = wr_addr[CELL_BITS-1:0];

    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            if (wr_lower) begin
                lower_mem[wr_cell] <= wr_data;
            end else begin
                upper_mem[wr_cell] <= wr_data;
            end
        end
    end

    // both halves read at the same row and column
    assign rd_cell = {row_address, column_address};
    assign upper_pixel = upper_mem[rd_cell];
    assign lower_pixel = lower_mem[rd_cell];

    // order r0 g0 b0 r1 g1 b1
    assign plane_bits = {
        plane_bit(upper_pixel[2], brightness_mask),
        plane_bit(upper_pixel[1], brightness_mask),
        plane_bit(upper_pixel[0], brightness_mask),
        plane_bit(lower_pixel[2], brightness_mask),
        plane_bit(lower_pixel[1], brightness_mask),
        plane_bit(lower_pixel[0], brightness_mask)
    };

    // panel shifts these in half a cycle later on clk_pixel
    always_ff @(posedge clk_pixel_load) begin
        if (reset) begin
            {r0, g0, b0, r1, g1, b1} <= 6'b0;
        end else begin
            {r0, g0, b0, r1, g1, b1} <= plane_bits;
        end
    end

endmodule

// File: design/timeout.sv
// loadable down-counter with a running flag
// counts from a loaded value to zero and holds there

`timescale 1ns/10ps

module timeout #(
    parameter int unsigned COUNTER_WIDTH = 8
) (
    input  logic                     reset,
    input  logic                     clk_in,
    // load value at the next rising edge
    input  logic                     start,
    input  logic [COUNTER_WIDTH-1:0] value,
    output logic [COUNTER_WIDTH-1:0] counter,
    // high while the count is nonzero
    output logic                     running
);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            counter <= '0;
        end else if (start) begin
            // a new start overrides a count in progress
            counter <= value;
        end else if (counter != '0) begin
            counter <= counter - 1'b1;
        end
    end

    // nonzero count means the window is still open
    assign running = (counter != '0);

endmodule

// File: design/types.sv
// HUB75 scan controller types
// address, brightness and latch phase types for the design and the testbench

`include "hub75_consts.svh"

package types;

    // column index within a row
    typedef logic [$clog2(`HUB75_PIXEL_WIDTH)-1:0] col_addr_t;

    // row within one subpanel
    typedef logic [$clog2(`HUB75_SUBPANEL_ROWS)-1:0] row_subpanel_addr_t;

    // framebuffer write address, laid out as {subpanel, row, column}
    // subpanel 0 is the upper half
    typedef logic [$bits(row_subpanel_addr_t)+$bits(col_addr_t):0] fb_addr_t;

    // one-hot plane select, MSB plane first
    typedef logic [`HUB75_BRIGHTNESS_BITS-1:0] brightness_level_t;

    // a single colour value
    typedef logic [`HUB75_BRIGHTNESS_BITS-1:0] channel_t;

    // row latch phase, stepped on the falling clock edge
    typedef enum logic [1:0] {
        IDLE,
        SHIFT,
        LATCH
    } latch_phase_t;

endpackage

// File: run.sh
#!/bin/sh
# build and run the HUB75 testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module hub75_tb -o vhub75_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/vhub75_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^RESULT: PASS$" sim.log; then
    exit 0
fi
exit 1

// File: verification/hub75_checker.sv
// HUB75 scan checker
// watches the write port and panel pins, compares against a shadow framebuffer

`timescale 1ns/10ps

`include "hub75_consts.svh"

module hub75_checker (
    input  logic                      clk_in,
    input  logic                      reset,
    input  logic                      wr_en,
    input  types::fb_addr_t           wr_addr,
    input  types::channel_t [2:0]     wr_data,
    input  logic                      r0,
    input  logic                      g0,
    input  logic                      b0,
    input  logic                      r1,
    input  logic                      g1,
    input  logic                      b1,
    input  logic                      clk_pixel,
    input  logic                      row_latch,
    input  logic                      output_enable,
    input  types::row_subpanel_addr_t row_address_active,
    input  types::col_addr_t          column_address,
    // rising edge prints the per-test summary
    input  logic                      report,
    output int                        check_count,
    output int                        error_count,
    output int                        latch_count
);

    import types::*;

    localparam int W = `HUB75_PIXEL_WIDTH;
    localparam int R = `HUB75_SUBPANEL_ROWS;
    localparam int B = `HUB75_BRIGHTNESS_BITS;
    localparam int CB = $clog2(W);
    localparam int RB = $clog2(R);

    // shadow copy of both subpanels, built from the write port
    logic [3*B-1:0] shadow [2][R][W];
    // bits seen on clk_pixel since the last latch, first entry is column W-1
    logic [5:0] shifted [2*W];
    int px_index;
    int px_latch_seen;

    // per test counters of the clk_in process
    int checks [6];
    int errors [6];
    // counters owned by the clk_pixel process
    int overlap_checks;
    int overlap_errors;
    int reset_px_errors;
    int col_checks;
    int col_errors;
    // column the address counter should show at this clk_pixel
    int next_col;

    int exp_row;
    int exp_plane;
    int pulse_len;
    int oe_count;
    int settle;
    logic oe_prev;

    // red, green, blue bit of one pixel at a plane
    function automatic logic [2:0] expected_bits(input int subpanel, input int row,
                                                 input int col, input int plane);
        logic [3*B-1:0] px;
        px = shadow[subpanel][row][col];
        return {px[2*B+plane], px[B+plane], px[plane]};
    endfunction

    task automatic value_check(input int test, input string name,
                               input int expected, input int actual);
        checks[test]++;
        if (expected != actual) begin
            errors[test]++;
            $display("ERROR t=%0t %s expected %0h got %0h", $time, name, expected, actual);
        end
    endtask

    task automatic condition_check(input int test, input logic ok, input string msg);
        checks[test]++;
        if (!ok) begin
            errors[test]++;
            $display("t=%0t %s", $time, msg);
        end
    endtask

    // plane just shifted is compared for the row and plane it makes active
    task automatic latch_event();
        logic [5:0] want;
        int col;
        value_check(0, "clk_pixel count", W, px_index);
        value_check(2, "row_address_active", exp_row, int'(row_address_active));
        for (int i = 0; i < px_index && i < W; i++) begin
            col = W - 1 - i;
            want = {expected_bits(0, exp_row, col, exp_plane),
                    expected_bits(1, exp_row, col, exp_plane)};
            value_check(1, $sformatf("colour lines col %0d", col), int'(want), int'(shifted[i]));
        end
        pulse_len = `HUB75_OE_BASE_CYCLES << exp_plane;
        oe_count = 0;
        // MSB to LSB, then the next row
        if (exp_plane == 0) begin
            exp_plane = B - 1;
            exp_row = (exp_row + 1) % R;
        end else begin
            exp_plane--;
        end
        latch_count++;
    endtask

    initial begin
        exp_row = 0;
        exp_plane = B - 1;
        pulse_len = 0;
        oe_count = 0;
        settle = 0;
        oe_prev = 1'b0;
        latch_count = 0;
        px_index = 0;
        px_latch_seen = 0;
        overlap_checks = 0;
        overlap_errors = 0;
        reset_px_errors = 0;
        col_checks = 0;
        col_errors = 0;
        next_col = 0;
        for (int i = 0; i < 6; i++) begin
            checks[i] = 0;
            errors[i] = 0;
        end
    end

    always @(posedge clk_in) begin
        if (wr_en) begin
            shadow[wr_addr[CB+RB]][wr_addr[CB+RB-1:CB]][wr_addr[CB-1:0]] = wr_data;
        end
        if (reset || settle < 2) begin
            value_check(5, "output_enable", 0, int'(output_enable));
            value_check(5, "row_latch", 0, int'(row_latch));
            settle = reset ? 0 : settle + 1;
        end else begin
            condition_check(4, !(row_latch && output_enable),
                            "row_latch was high while output_enable was high");
            // pulse end comes before a latch on the same edge
            if (output_enable) begin
                oe_count++;
            end else if (oe_prev) begin
                value_check(3, "output_enable pulse length", pulse_len, oe_count);
            end
            oe_prev = output_enable;
            if (row_latch) begin
                latch_event();
            end
        end
    end

    // colour lines are stable here, they change on the clk_in rising edge
    always @(posedge clk_pixel) begin
        if (reset || settle < 2) begin
            reset_px_errors++;
            $display("t=%0t clk_pixel pulsed during or just after reset", $time);
        end else begin
            if (px_latch_seen != latch_count) begin
                px_index = 0;
                px_latch_seen = latch_count;
            end
            if (px_index == 0) begin
                overlap_checks++;
                if (output_enable && (pulse_len - oe_count) > `HUB75_OVERLAP_CYCLES) begin
                    overlap_errors++;
                    $display("t=%0t next plane started with %0d enable cycles still left",
                             $time, pulse_len - oe_count);
                end
            end
            if (px_index < W) begin
                // the load edge that captured this column already stepped to the next one
                // the count holds at 0 after the last column
                next_col = (px_index < W - 1) ? W - 2 - px_index : 0;
                col_checks++;
                if (int'(column_address) != next_col) begin
                    col_errors++;
                    $display("ERROR t=%0t column_address expected %0h got %0h",
                             $time, next_col, column_address);
                end
            end
            if (px_index < 2 * W) begin
                shifted[px_index] = {r0, g0, b0, r1, g1, b1};
                px_index++;
            end
        end
    end

    always @(posedge report) begin
        $display("test 1 pixel count: %0d checks, %0d errors", checks[0], errors[0]);
        $display("test 2 shifted data: %0d checks, %0d errors",
                 checks[1] + col_checks, errors[1] + col_errors);
        $display("test 3 plane and row order: %0d checks, %0d errors", checks[2], errors[2]);
        $display("test 4 enable length: %0d checks, %0d errors", checks[3], errors[3]);
        $display("test 5 overlap: %0d checks, %0d errors",
                 checks[4] + overlap_checks, errors[4] + overlap_errors);
        $display("test 6 reset values: %0d checks, %0d errors",
                 checks[5], errors[5] + reset_px_errors);
        check_count = checks[0] + checks[1] + checks[2] + checks[3] + checks[4] + checks[5]
                      + overlap_checks + col_checks;
        error_count = errors[0] + errors[1] + errors[2] + errors[3] + errors[4] + errors[5]
                      + overlap_errors + reset_px_errors + col_errors;
    end

endmodule

// File: verification/hub75_tb.sv
// HUB75 controller testbench
// fills the framebuffer with LFSR data and lets the checker follow the scan

`timescale 1ns/10ps

`include "hub75_consts.svh"

module hub75_tb;

    import types::*;

    localparam int B = `HUB75_BRIGHTNESS_BITS;
    localparam int FILL_DEPTH = 2 * `HUB75_SUBPANEL_ROWS * `HUB75_PIXEL_WIDTH;
    // every plane of every row, then a few more to see the row wrap
    localparam int LATCH_TARGET = `HUB75_SUBPANEL_ROWS * B + 4;
    localparam int LATCH_TIMEOUT = 1000;
    localparam logic [31:0] SEED = 32'hc4c7;
    // x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] TAPS = 32'h80200003;

    logic clk_in = 1'b0;
    logic reset = 1'b1;
    logic wr_en = 1'b0;
    fb_addr_t wr_addr = '0;
    channel_t [2:0] wr_data = '0;
    logic report = 1'b0;

    logic r0, g0, b0, r1, g1, b1;
    logic clk_pixel, row_latch, output_enable;
    row_subpanel_addr_t row_address_active;
    col_addr_t column_address;

    int check_count;
    int error_count;
    int latch_count;
    logic [31:0] lfsr_state;
    logic timed_out;

    always #10 clk_in = !clk_in;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ TAPS;
        end
        return s >> 1;
    endfunction

    // one LFSR step per bit taken
    task automatic take_random(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits[i] = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    hub75_top dut (
        .clk_in(clk_in), .reset(reset),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .r0(r0), .g0(g0), .b0(b0), .r1(r1), .g1(g1), .b1(b1),
        .clk_pixel(clk_pixel), .row_latch(row_latch), .output_enable(output_enable),
        .row_address_active(row_address_active), .column_address(column_address)
    );

    hub75_checker check (
        .clk_in(clk_in), .reset(reset),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .r0(r0), .g0(g0), .b0(b0), .r1(r1), .g1(g1), .b1(b1),
        .clk_pixel(clk_pixel), .row_latch(row_latch), .output_enable(output_enable),
        .row_address_active(row_address_active), .column_address(column_address),
        .report(report),
        .check_count(check_count), .error_count(error_count), .latch_count(latch_count)
    );

    initial begin
        logic [31:0] bits;
        int cycles;
        lfsr_state = SEED;
        timed_out = 1'b0;
        repeat (8) @(posedge clk_in);
        // scan stays in reset while the framebuffer fills
        for (int a = 0; a < FILL_DEPTH; a++) begin
            @(posedge clk_in);
            #2;
            take_random(3 * B, bits);
            wr_en = 1'b1;
            wr_addr = fb_addr_t'(a);
            wr_data = bits[3*B-1:0];
        end
        @(posedge clk_in);
        #2;
        wr_en = 1'b0;
        reset = 1'b0;
        for (int n = 1; n <= LATCH_TARGET; n++) begin
            cycles = 0;
            while (latch_count < n && cycles < LATCH_TIMEOUT) begin
                @(posedge clk_in);
                cycles++;
            end
            if (latch_count < n) begin
                $display("timeout: row latch %0d did not come within %0d cycles",
                         n, LATCH_TIMEOUT);
                timed_out = 1'b1;
                break;
            end
        end
        report = 1'b1;
        #1;
        $display("checks %0d, errors %0d, latches %0d", check_count, error_count, latch_count);
        if (!timed_out && error_count == 0 && check_count > 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
